// File: source/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// First fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// A jump or branch landing here stops the CPU
`define MIPS_HALT_ADDR 32'h0000_0000

// Architectural register file size
`define MIPS_NUM_REGS 32

// Register indices with a fixed role
`define MIPS_REG_V0 5'd2
`define MIPS_REG_RA 5'd31

`endif

// File: source/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTIU   = 6'h0B,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    // Function codes under SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_e;

    // R-type view of the instruction word
    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } instr_fields_t;

endpackage

`default_nettype wire

// File: source/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    // Next PC source
    typedef enum logic [1:0] {
        PC_SEQ,
        PC_BRANCH,
        PC_JUMP,
        PC_JUMP_REG
    } pc_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    imm_signed;
        logic    shift_src_shamt;
        logic    reg_write;
        logic    reg_dst_rd;
        logic    link_ra;
        logic    mem_to_reg;
        logic    mem_read;
        logic    mem_write;
        logic    branch_on_equal;
        logic    is_branch;
        pc_sel_e pc_sel;
    } ctrl_word_t;

endpackage

`default_nettype wire

// File: source/mips_control.sv
`timescale 1ns/10ps
`default_nettype none

module mips_control (
    input  mips_isa_pkg::instr_fields_t fields,
    input  logic                        step,
    output mips_ctrl_pkg::ctrl_word_t   ctrl
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    ctrl_word_t dec;

    always_comb begin
        // Anything not listed decodes as a no-op
        dec = '0;
        dec.alu_op = ALU_ADD;
        dec.pc_sel = PC_SEQ;

        case (fields.opcode)
            OP_SPECIAL: begin
                dec.reg_dst_rd = 1'b1;
                dec.reg_write = 1'b1;
                case (fields.funct)
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_SLTU: dec.alu_op = ALU_SLTU;
                    FN_SLL: begin
                        dec.alu_op = ALU_SLL;
                        dec.shift_src_shamt = 1'b1;
                    end
                    FN_SRL: begin
                        dec.alu_op = ALU_SRL;
                        dec.shift_src_shamt = 1'b1;
                    end
                    FN_JR: begin
                        dec.reg_write = 1'b0;
                        dec.pc_sel = PC_JUMP_REG;
                    end
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                dec.alu_src_imm = 1'b1;
                dec.reg_write = 1'b1;
                dec.imm_signed = (fields.opcode == OP_ADDIU) || (fields.opcode == OP_SLTIU);
                case (fields.opcode)
                    OP_SLTIU: dec.alu_op = ALU_SLTU;
                    OP_ANDI:  dec.alu_op = ALU_AND;
                    OP_ORI:   dec.alu_op = ALU_OR;
                    OP_XORI:  dec.alu_op = ALU_XOR;
                    OP_LUI:   dec.alu_op = ALU_LUI;
                    default:  dec.alu_op = ALU_ADD;
                endcase
            end
            OP_LW, OP_SW: begin
                dec.alu_src_imm = 1'b1;
                dec.imm_signed = 1'b1;
                dec.mem_read = (fields.opcode == OP_LW);
                dec.mem_to_reg = (fields.opcode == OP_LW);
                dec.reg_write = (fields.opcode == OP_LW);
                dec.mem_write = (fields.opcode == OP_SW);
            end
            OP_BEQ, OP_BNE: begin
                // Compare by subtraction, the zero flag decides
                dec.alu_op = ALU_SUB;
                dec.imm_signed = 1'b1;
                dec.is_branch = 1'b1;
                dec.branch_on_equal = (fields.opcode == OP_BEQ);
                dec.pc_sel = PC_BRANCH;
            end
            OP_J: dec.pc_sel = PC_JUMP;
            OP_JAL: begin
                dec.pc_sel = PC_JUMP;
                dec.link_ra = 1'b1;
                dec.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

    // State changes only on a stepping edge
    always_comb begin
        ctrl = dec;
        ctrl.reg_write = dec.reg_write & step;
        ctrl.mem_write = dec.mem_write & step;
        ctrl.mem_read = dec.mem_read & step;
    end

endmodule

`default_nettype wire

// File: source/mips_alu.sv
`timescale 1ns/10ps
`default_nettype none

module mips_alu (
    input  mips_ctrl_pkg::alu_op_e alu_op,
    input  logic [31:0]            op_a,
    input  logic [31:0]            op_b,
    input  logic [4:0]             shamt,
    output logic [31:0]            result,
    output logic                   zero
);
    import mips_ctrl_pkg::*;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SLT: begin
                result = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            ALU_SLTU: begin
                result = {31'b0, op_a < op_b};
            end
            // Shifts act on the rt operand
            ALU_SLL:  result = op_b << shamt;
            ALU_SRL:  result = op_b >> shamt;
            ALU_LUI:  result = {op_b[15:0], 16'h0000};
            default:  result = 32'h0000_0000;
        endcase
    end

    // Used by BEQ and BNE
    assign zero = (result == 32'h0000_0000);

endmodule

`default_nettype wire

// File: source/mips_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_consts.svh"

module mips_regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs_index,
    input  logic [4:0]  rt_index,
    input  logic [4:0]  wr_index,
    input  logic        wr_en,
    input  logic [31:0] wr_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] v0
);

    logic [31:0] regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= 32'h0000_0000;
            end
        end else if (wr_en && wr_index != 5'd0) begin
            regs[wr_index] <= wr_data;
        end
    end

    // Register 0 is hardwired
    assign rs_data = (rs_index == 5'd0) ? 32'h0000_0000 : regs[rs_index];
    assign rt_data = (rt_index == 5'd0) ? 32'h0000_0000 : regs[rt_index];

    assign v0 = regs[`MIPS_REG_V0];

endmodule

`default_nettype wire

// File: source/mips_pc.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_consts.svh"

module mips_pc (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      clk_enable,
    input  mips_ctrl_pkg::ctrl_word_t ctrl,
    input  logic                      zero,
    input  logic [31:0]               imm_ext,
    input  logic [25:0]               jump_target,
    input  logic [31:0]               rs_data,
    output logic [31:0]               pc,
    output logic [31:0]               pc_plus4,
    output logic                      active,
    output logic                      step
);
    import mips_ctrl_pkg::*;

    logic [31:0] next_pc;
    logic        branch_taken;
    logic        redirect;

    assign pc_plus4 = pc + 32'd4;
    assign step = active & clk_enable & ~rst;

    assign branch_taken = ctrl.is_branch && (zero == ctrl.branch_on_equal);

    always_comb begin
        case (ctrl.pc_sel)
            PC_BRANCH: begin
                next_pc = branch_taken ? pc_plus4 + {imm_ext[29:0], 2'b00} : pc_plus4;
            end
            PC_JUMP:     next_pc = {pc_plus4[31:28], jump_target, 2'b00};
            PC_JUMP_REG: next_pc = rs_data;
            default:     next_pc = pc_plus4;
        endcase
    end

    // Only a real change of flow may halt
    assign redirect = (ctrl.pc_sel == PC_JUMP) || (ctrl.pc_sel == PC_JUMP_REG) ||
                      (ctrl.pc_sel == PC_BRANCH && branch_taken);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `MIPS_RESET_VECTOR;
            active <= 1'b1;
        end else if (step) begin
            pc <= next_pc;
            if (redirect && next_pc == `MIPS_HALT_ADDR) begin
                active <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/mips_cpu_harvard.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_consts.svh"

module mips_cpu_harvard (
    input  logic        clk,
    input  logic        rst,
    output logic        active,
    output logic [31:0] register_v0,

    input  logic        clk_enable,

    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,

    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    instr_fields_t fields;
    ctrl_word_t    ctrl;
    logic          step;

    logic [31:0] imm_ext;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [4:0]  wr_index;
    logic [31:0] wr_data;
    logic [31:0] alu_b;
    logic [4:0]  alu_shamt;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic [31:0] pc_plus4;

    assign fields = instr_fields_t'(instr_readdata);

    mips_control u_control (
        .fields(fields),
        .step(step),
        .ctrl(ctrl)
    );

    // Immediate sits in the low half of the raw word
    assign imm_ext = ctrl.imm_signed ? {{16{instr_readdata[15]}}, instr_readdata[15:0]}
                                     : {16'h0000, instr_readdata[15:0]};

    assign wr_index = ctrl.link_ra ? `MIPS_REG_RA : (ctrl.reg_dst_rd ? fields.rd : fields.rt);

    // JAL links PC+4, no delay slot
    assign wr_data = ctrl.link_ra ? pc_plus4 : (ctrl.mem_to_reg ? data_readdata : alu_result);

    mips_regfile u_regfile (
        .clk(clk),
        .rst(rst),
        .rs_index(fields.rs),
        .rt_index(fields.rt),
        .wr_index(wr_index),
        .wr_en(ctrl.reg_write),
        .wr_data(wr_data),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .v0(register_v0)
    );

    assign alu_b = ctrl.alu_src_imm ? imm_ext : rt_data;
    assign alu_shamt = ctrl.shift_src_shamt ? fields.shamt : rs_data[4:0];

    mips_alu u_alu (
        .alu_op(ctrl.alu_op),
        .op_a(rs_data),
        .op_b(alu_b),
        .shamt(alu_shamt),
        .result(alu_result),
        .zero(alu_zero)
    );

    mips_pc u_pc (
        .clk(clk),
        .rst(rst),
        .clk_enable(clk_enable),
        .ctrl(ctrl),
        .zero(alu_zero),
        .imm_ext(imm_ext),
        .jump_target(instr_readdata[25:0]),
        .rs_data(rs_data),
        .pc(instr_address),
        .pc_plus4(pc_plus4),
        .active(active),
        .step(step)
    );

    assign data_address = alu_result;
    assign data_writedata = rt_data;
    assign data_write = ctrl.mem_write;
    assign data_read = ctrl.mem_read;

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // 10 ns period
    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

endmodule

`default_nettype wire

// File: verification/tb_mips_cpu.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_consts.svh"

module tb_mips_cpu;

    localparam STIM_FILE = "verification/cpu_stimulus.txt";

    logic        clk;
    logic        rst;
    logic        clk_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    logic [31:0] rom [1024];
    logic [31:0] ram [1024];
    logic [31:0] rom_offset;

    // Records of the test being collected
    logic [31:0] p_addr [$];
    logic [31:0] p_data [$];
    logic [31:0] d_addr [$];
    logic [31:0] d_data [$];
    logic [31:0] m_addr [$];
    logic [31:0] m_data [$];
    logic [31:0] exp_v0;

    logic [15:0] lfsr;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 1000000;

    tb_clock_gen clock0 (.clk(clk));

    mips_cpu_harvard dut0 (
        .clk(clk),
        .rst(rst),
        .active(active),
        .register_v0(register_v0),
        .clk_enable(clk_enable),
        .instr_address(instr_address),
        .instr_readdata(instr_readdata),
        .data_address(data_address),
        .data_write(data_write),
        .data_read(data_read),
        .data_writedata(data_writedata),
        .data_readdata(data_readdata)
    );

    // ROM starts at the reset vector, outside it every fetch is sw $0, 0($0)
    assign rom_offset = instr_address - `MIPS_RESET_VECTOR;
    assign instr_readdata = (rom_offset < 32'd4096) ? rom[rom_offset[11:2]] : 32'hAC00_0000;
    assign data_readdata = ram[data_address[11:2]];

    always @(posedge clk) begin
        if (data_write) begin
            ram[data_address[11:2]] = data_writedata;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: the CPU did not halt within %0d cycles", limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Single-character record tag, skipping comment lines
    task automatic next_token(input int fd, output logic [7:0] tok);
        string rest;
        int    code;
        tok = "#";
        while (tok == "#") begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                tok = 8'h00;
            end else if (tok == "#") begin
                code = $fgets(rest, fd);
            end
        end
    endtask

    task automatic run_pass(input logic gated);
        logic [31:0] off;
        logic        b0;
        logic        b1;
        for (int i = 0; i < 1024; i++) begin
            rom[i] = 32'h0000_0000;
            ram[i] = 32'(i * 4) * 32'h9E37_79B1;
        end
        foreach (d_addr[k]) begin
            ram[d_addr[k][11:2]] = d_data[k];
        end

        @(negedge clk);
        rst = 1'b1;
        clk_enable = 1'b1;
        // Loads and then stores wait at the reset vector during reset
        for (int c = 0; c < 8; c++) begin
            rom[0] = (c < 4) ? 32'h8C00_0000 : 32'hAC00_0000;
            @(negedge clk);
            checks++;
            if (data_write !== 1'b0) begin
                errors++;
                $display("** Error: data_write = %h in reset, expected 0", data_write);
            end
            checks++;
            if (data_read !== 1'b0) begin
                errors++;
                $display("** Error: data_read = %h in reset, expected 0", data_read);
            end
        end
        rom[0] = 32'h0000_0000;
        foreach (p_addr[k]) begin
            off = p_addr[k] - `MIPS_RESET_VECTOR;
            rom[off[11:2]] = p_data[k];
        end
        rst = 1'b0;
        checks++;
        if (active !== 1'b1) begin
            errors++;
            $display("** Error: active = %h after reset, expected 1", active);
        end
        checks++;
        if (instr_address !== `MIPS_RESET_VECTOR) begin
            errors++;
            $display("** Error: instr_address = %h after reset, expected %h",
                     instr_address, `MIPS_RESET_VECTOR);
        end

        while (active === 1'b1) begin
            if (gated) begin
                lfsr = lfsr_step(lfsr);
                b0 = lfsr[0];
                lfsr = lfsr_step(lfsr);
                b1 = lfsr[0];
                clk_enable = b0 | b1;
            end else begin
                clk_enable = 1'b1;
            end
            @(negedge clk);
        end

        // Halted CPU must stay frozen
        clk_enable = 1'b1;
        repeat (4) begin
            @(negedge clk);
            checks++;
            if (data_write !== 1'b0) begin
                errors++;
                $display("** Error: data_write = %h after halt, expected 0", data_write);
            end
            checks++;
            if (instr_address !== `MIPS_HALT_ADDR) begin
                errors++;
                $display("** Error: instr_address = %h after halt, expected %h",
                         instr_address, `MIPS_HALT_ADDR);
            end
        end

        checks++;
        if (register_v0 !== exp_v0) begin
            errors++;
            $display("** Error: register_v0 = %h, expected %h (gated %0d)",
                     register_v0, exp_v0, gated);
        end
        foreach (m_addr[k]) begin
            checks++;
            if (ram[m_addr[k][11:2]] !== m_data[k]) begin
                errors++;
                $display("** Error: data RAM word %h = %h, expected %h",
                         m_addr[k], ram[m_addr[k][11:2]], m_data[k]);
            end
        end
    endtask

    initial begin
        logic [7:0]  tok;
        logic [31:0] a;
        logic [31:0] v;
        int          fd;
        int          code;
        int          words;
        rst = 1'b1;
        clk_enable = 1'b0;
        lfsr = 16'd21;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", STIM_FILE);
            $display("RESULT: FAIL");
            $finish;
        end else begin
            // First pass sizes the timeout
            words = 0;
            next_token(fd, tok);
            while (tok != 8'h00) begin
                if (tok == "P") begin
                    words++;
                end
                next_token(fd, tok);
            end
            $fclose(fd);
            limit = 16 * words + 200;

            fd = $fopen(STIM_FILE, "r");
            next_token(fd, tok);
            while (tok != 8'h00) begin
                case (tok)
                    "P": begin
                        code = $fscanf(fd, "%h %h", a, v);
                        p_addr.push_back(a);
                        p_data.push_back(v);
                    end
                    "D": begin
                        code = $fscanf(fd, "%h %h", a, v);
                        d_addr.push_back(a);
                        d_data.push_back(v);
                    end
                    "M": begin
                        code = $fscanf(fd, "%h %h", a, v);
                        m_addr.push_back(a);
                        m_data.push_back(v);
                    end
                    "V": code = $fscanf(fd, "%h", exp_v0);
                    "R": begin
                        run_pass(1'b0);
                        run_pass(1'b1);
                        p_addr.delete();
                        p_data.delete();
                        d_addr.delete();
                        d_data.delete();
                        m_addr.delete();
                        m_data.delete();
                    end
                    default: begin
                        errors++;
                        $display("Unknown record tag in the stimulus file");
                    end
                endcase
                next_token(fd, tok);
            end
            $fclose(fd);

            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verification/cpu_stimulus.txt
# P addr instr | D addr data | M addr expected data | V expected v0 | R run test
# All values hex, programs end with jr $0 to halt
# ALU test
P bfc00000 24080123  P bfc00004 3c098000  P bfc00008 352900f0
P bfc0000c 01095021  P bfc00010 01485823  P bfc00014 01496024
P bfc00018 010c6825  P bfc0001c 01aa7026  P bfc00020 0128782a
P bfc00024 0109c02b  P bfc00028 000ec900  P bfc0002c 000b8102
P bfc00030 2d12ffff  P bfc00034 31b3ffff  P bfc00038 3a748000
P bfc0003c 03301021  P bfc00040 004f1021  P bfc00044 00521021
P bfc00048 00541026  P bfc0004c 00581021  P bfc00050 00000008
V 0800b323
R
# Load and store test
P bfc00000 24080040  P bfc00004 8d090000  P bfc00008 252a0001
P bfc0000c ad0a0004  P bfc00010 ad09fffc  P bfc00014 8d020004
P bfc00018 00000008
D 00000040 12345678
M 00000040 12345678  M 00000044 12345679  M 0000003c 12345678
V 12345679
R
# Branch and jump test
P bfc00000 24020001  P bfc00004 10400001  P bfc00008 24420002
P bfc0000c 14400001  P bfc00010 24420100  P bfc00014 10000001
P bfc00018 24420200  P bfc0001c 14420001  P bfc00020 24420004
P bfc00024 0ff00010  P bfc00028 24420008  P bfc0002c 0bf0000e
P bfc00030 24420400  P bfc00038 00000008  P bfc00040 24420010
P bfc00044 03e00008
V 0000001f
R

// File: all.f
+incdir+source
source/mips_isa_pkg.sv
source/mips_ctrl_pkg.sv
source/mips_control.sv
source/mips_alu.sv
source/mips_regfile.sv
source/mips_pc.sv
source/mips_cpu_harvard.sv
verification/tb_clock_gen.sv
verification/tb_mips_cpu.sv

// File: Makefile
# Verilator build and run for the MIPS CPU testbench
VERILATOR ?= verilator
TOP       ?= tb_mips_cpu
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
